// File: src/u712Pkg.sv
// Widths are fixed by the 68040 and Agnus buses and are not meant to be changed
`default_nettype none

package u712Pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    // CPU address pins A[20:0]
    typedef logic [20:0] cpuAddr;
    // Multiplexed SDRAM address CMA
    typedef logic [10:0] ramAddr;
    // Agnus DRAM address DRA
    typedef logic [9:0] dmaAddr;
    // 68040 SIZ encoding
    typedef logic [1:0] busSize;
    // Active low lanes, UU in bit 3 down to LL in bit 0
    typedef logic [3:0] byteEn;

    ////////////////////
    // State machines
    ////////////////////

    // Agnus 68000-style register cycle
    typedef enum logic [2:0] {regIdle, regWaitPhase, regStrobe, regHold, regAck} regState;

    // Chip RAM sequencer for CPU accesses
    typedef enum logic [2:0] {
        ramIdle, ramActivate, ramRcdWait, ramCommand, ramCasWait, ramAck
    } ramState;

    ////////////////////
    // Bus bundles
    ////////////////////

    // CPU transfer request, start and write are active high
    typedef struct packed {
        logic   start;
        logic   write;
        cpuAddr addr;
        busSize size;
    } cpuReq;

    // Agnus DMA strobes, all active low
    typedef struct packed {
        logic   ras0n;
        logic   ras1n;
        logic   casLn;
        logic   casUn;
        logic   aWen;
        dmaAddr dra;
    } dmaBus;

    // SDRAM command pins
    typedef struct packed {
        logic [1:0] bank;
        logic       rasN;
        logic       casN;
        logic       weN;
        logic       crcsN;
        logic       clkEn;
        ramAddr     addr;
    } sdramCmd;

endpackage

`default_nettype wire

// File: src/regCycle.sv
// C1 and C3 are sampled on CLK80 and only the rising edge of the C1-high C3-low phase counts
`timescale 1ns/1ps
`default_nettype none

module regCycle import u712Pkg::*; (
    input  wire  CLK80,
    input  wire  RESETn,
    input  wire  C1,
    input  wire  C3,
    input  wire  TSn,
    input  wire  REGSPACEn,
    input  wire  DBRn,
    output logic ASn,
    output logic REGENn,
    output logic regTack,
    output logic dsEnable,
    output logic dbrSync
);

    ////////////////////
    // DBRn sync
    ////////////////////

    // Two flops, idle high so no DMA is seen out of reset
    logic [1:0] dbrQ;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            dbrQ <= 2'b11;
        end else begin
            dbrQ <= {dbrQ[0], DBRn};
        end
    end

    // Shared with the chip RAM side
    assign dbrSync = dbrQ[1];

    ////////////////////
    // Phase detect
    ////////////////////

    logic phaseNow;
    logic phaseQ;
    logic phaseEdge;
    logic regStart;

    // Agnus phase where the 68000 cycle may begin or end
    assign phaseNow  = C1 & ~C3;
    // First CLK80 cycle of that phase
    assign phaseEdge = phaseNow & ~phaseQ;
    // Register space access from the CPU
    assign regStart  = ~TSn & ~REGSPACEn;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            phaseQ <= 1'b0;
        end else begin
            phaseQ <= phaseNow;
        end
    end

    ////////////////////
    // Cycle FSM
    ////////////////////

    regState state;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state    <= regIdle;
            ASn      <= 1'b1;
            REGENn   <= 1'b1;
            regTack  <= 1'b0;
            dsEnable <= 1'b0;
        end else begin
            // Tack is a single cycle pulse
            regTack <= 1'b0;
            case (state)
                regIdle: begin
                    if (regStart) begin
                        state <= regWaitPhase;
                    end
                end
                regWaitPhase: begin
                    // Address strobe and register enable together
                    if (phaseEdge) begin
                        ASn    <= 1'b0;
                        REGENn <= 1'b0;
                        state  <= regStrobe;
                    end
                end
                regStrobe: begin
                    // Data strobes trail AS by one clock
                    dsEnable <= 1'b1;
                    state    <= regHold;
                end
                regHold: begin
                    // Release everything when the phase comes around again
                    if (phaseEdge) begin
                        ASn      <= 1'b1;
                        REGENn   <= 1'b1;
                        dsEnable <= 1'b0;
                        regTack  <= 1'b1;
                        state    <= regAck;
                    end
                end
                regAck: begin
                    state <= regIdle;
                end
                default: begin
                    state <= regIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/chipRamCycle.sv
// CPU requests wait in idle during DMA and a DMA start does not abort a CPU cycle already running
`timescale 1ns/1ps
`default_nettype none

module chipRamCycle import u712Pkg::*; (
    input  wire     CLK80,
    input  wire     RESETn,
    input  wire     cpuReq req,
    input  wire     RAMSPACEn,
    input  wire     dmaBus dma,
    input  wire     dbrSync,
    output sdramCmd cmd,
    output logic    cpuCycle,
    output logic    dmaCycle,
    output logic    cpuTack,
    output logic    DBENn,
    output logic    DBDIR
);

    ////////////////////
    // Address split
    ////////////////////

    logic [1:0] bankSel;
    ramAddr     rowAddr;
    ramAddr     colAddr;

    // 2 MB space as four banks of 2k rows
    assign bankSel = req.addr[20:19];
    assign rowAddr = req.addr[18:8];
    // Longword column, upper bits unused
    assign colAddr = {5'b00000, req.addr[7:2]};

    ////////////////////
    // Sequencer
    ////////////////////

    ramState state;
    logic    waitCnt;
    logic    pending;
    logic    ramStart;
    logic    goCpu;

    // TSn is one cycle only so a request seen during DMA is remembered
    assign ramStart = req.start & ~RAMSPACEn;
    assign goCpu    = (ramStart | pending) & dbrSync;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state   <= ramIdle;
            waitCnt <= 1'b0;
            pending <= 1'b0;
        end else begin
            case (state)
                ramIdle: begin
                    if (goCpu) begin
                        pending <= 1'b0;
                        state   <= ramActivate;
                    end else if (ramStart) begin
                        // Agnus owns the RAM for now
                        pending <= 1'b1;
                    end
                end
                ramActivate: begin
                    waitCnt <= 1'b0;
                    state   <= ramRcdWait;
                end
                ramRcdWait: begin
                    // tRCD of two clocks
                    if (waitCnt) begin
                        waitCnt <= 1'b0;
                        state   <= ramCommand;
                    end else begin
                        waitCnt <= 1'b1;
                    end
                end
                ramCommand: begin
                    // Writes finish right away, reads wait for CAS latency
                    state <= req.write ? ramAck : ramCasWait;
                end
                ramCasWait: begin
                    if (waitCnt) begin
                        waitCnt <= 1'b0;
                        state   <= ramAck;
                    end else begin
                        waitCnt <= 1'b1;
                    end
                end
                ramAck: begin
                    state <= ramIdle;
                end
                default: begin
                    state <= ramIdle;
                end
            endcase
        end
    end

    ////////////////////
    // SDRAM pins
    ////////////////////

    sdramCmd cpuCmd;
    sdramCmd dmaCmd;

    // CPU side, NOP unless activating or issuing the command
    always_comb begin
        cpuCmd.bank  = bankSel;
        cpuCmd.rasN  = 1'b1;
        cpuCmd.casN  = 1'b1;
        cpuCmd.weN   = 1'b1;
        cpuCmd.crcsN = 1'b1;
        cpuCmd.clkEn = 1'b1;
        cpuCmd.addr  = rowAddr;
        if (state == ramActivate) begin
            cpuCmd.rasN  = 1'b0;
            cpuCmd.crcsN = 1'b0;
        end
        if (state == ramCommand) begin
            cpuCmd.casN  = 1'b0;
            cpuCmd.weN   = ~req.write;
            cpuCmd.crcsN = 1'b0;
            cpuCmd.addr  = colAddr;
        end
    end

    // Agnus side, strobes go straight through
    always_comb begin
        dmaCmd.bank  = {~dma.ras1n, 1'b0};
        dmaCmd.rasN  = dma.ras0n & dma.ras1n;
        dmaCmd.casN  = dma.casLn & dma.casUn;
        dmaCmd.weN   = dma.aWen;
        dmaCmd.crcsN = 1'b0;
        dmaCmd.clkEn = 1'b1;
        dmaCmd.addr  = {1'b0, dma.dra};
    end

    assign cmd = dbrSync ? cpuCmd : dmaCmd;

    // Ownership and status
    assign dmaCycle = ~dbrSync;
    assign cpuCycle = (state != ramIdle);
    assign cpuTack  = (state == ramAck);

    // CPU data buffer open from the command to the end
    assign DBENn = ~((state == ramCommand) | (state == ramCasWait) | (state == ramAck));
    // High drives CPU data toward the RAM
    assign DBDIR = req.write;

endmodule

`default_nettype wire

// File: src/byteLaneControl.sv
// Big-endian 68040 lanes and register strobes map onto both words of the 32-bit bus
`timescale 1ns/1ps
`default_nettype none

module byteLaneControl import u712Pkg::*; (
    input  wire   cpuReq req,
    input  wire   cpuCycle,
    input  wire   dmaCycle,
    input  wire   dsEnable,
    input  wire   CASLn,
    input  wire   CASUn,
    input  wire   RnW,
    input  wire   AWEn,
    output byteEn ramBe,
    output logic  UDSn,
    output logic  LDSn,
    output logic  VBENn,
    output logic  DRDENn,
    output logic  DRDDIR
);

    ////////////////////
    // CPU lanes
    ////////////////////

    byteEn cpuBe;

    always_comb begin
        case (req.size)
            // Byte, one lane from A[1:0]
            2'b01: begin
                cpuBe = 4'b1111;
                cpuBe[3 - req.addr[1:0]] = 1'b0;
            end
            // Word, upper or lower pair
            2'b10: cpuBe = req.addr[1] ? 4'b1100 : 4'b0011;
            // Long and line use all four
            default: cpuBe = 4'b0000;
        endcase
    end

    // DMA lanes come in pairs from the CAS strobes
    always_comb begin
        if (dmaCycle) begin
            ramBe = {CASUn, CASUn, CASLn, CASLn};
        end else if (cpuCycle) begin
            ramBe = cpuBe;
        end else begin
            ramBe = 4'b1111;
        end
    end

    ////////////////////
    // Register strobes
    ////////////////////

    // Even byte of either word is UDS, odd byte is LDS
    assign UDSn = ~(dsEnable & (~cpuBe[3] | ~cpuBe[1]));
    assign LDSn = ~(dsEnable & (~cpuBe[2] | ~cpuBe[0]));

    // Register data buffer
    assign VBENn = ~dsEnable;

    // Agnus data buffer, open only while Agnus owns the RAM
    assign DRDENn = ~dmaCycle;
    // High is the read direction on both sources
    assign DRDDIR = dmaCycle ? AWEn : RnW;

endmodule

`default_nettype wire

// File: src/cycleTerm.sv
// Both tack inputs must be single-cycle pulses on CLK80 and never overlap a second transfer
`timescale 1ns/1ps
`default_nettype none

module cycleTerm (
    input  wire  CLK80,
    input  wire  RESETn,
    input  wire  regTack,
    input  wire  cpuTack,
    output logic TACKn
);

    ////////////////////
    // Termination
    ////////////////////

    logic anyTack;

    // Only one source is active per transfer
    assign anyTack = regTack | cpuTack;

    // Straight from a flop so the CPU sees a clean edge
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            TACKn <= 1'b1;
        end else begin
            // Low for one clock, one clock behind the pulse
            TACKn <= ~anyTack;
        end
    end

endmodule

`default_nettype wire

// File: src/u712Top.sv
// CLK80 enters directly with no PLL and Agnus handles SDRAM refresh and init
`timescale 1ns/1ps
`default_nettype none

module u712Top import u712Pkg::*; (
    input  wire    CLK80,
    input  wire    C1,
    input  wire    C3,
    input  wire    RESETn,
    input  wire    RnW,
    input  wire    TSn,
    input  wire    DBRn,
    input  wire    REGSPACEn,
    input  wire    RAMSPACEn,
    input  wire    AWEn,
    input  wire    RAS0n,
    input  wire    RAS1n,
    input  wire    CASLn,
    input  wire    CASUn,
    input  wire    busSize SIZ,
    input  wire    cpuAddr A,
    input  wire    dmaAddr DRA,
    output logic   LDSn,
    output logic   UDSn,
    output logic   ASn,
    output logic   REGENn,
    output logic   DBDIR,
    output logic   VBENn,
    output logic   DRDENn,
    output logic   DRDDIR,
    output logic   CRCSn,
    output logic   CLK_EN,
    output logic   BANK1,
    output logic   BANK0,
    output logic   RASn,
    output logic   CASn,
    output logic   WEn,
    output logic   DBENn,
    output ramAddr CMA,
    output logic   CUUBEn,
    output logic   CUMBEn,
    output logic   CLMBEn,
    output logic   CLLBEn,
    output logic   TACKn
);

    ////////////////////
    // Pin bundles
    ////////////////////

    cpuReq   req;
    dmaBus   dma;
    sdramCmd cmd;
    byteEn   ramBe;
    logic    regTack;
    logic    cpuTack;
    logic    dsEnable;
    logic    dbrSync;
    logic    cpuCycle;
    logic    dmaCycle;

    // Start and write as active high flags
    assign req = {~TSn, ~RnW, A, SIZ};
    assign dma = {RAS0n, RAS1n, CASLn, CASUn, AWEn, DRA};

    // SDRAM and lane pins
    assign {BANK1, BANK0, RASn, CASn, WEn, CRCSn, CLK_EN, CMA} = cmd;
    assign {CUUBEn, CUMBEn, CLMBEn, CLLBEn} = ramBe;

    ////////////////////
    // Blocks
    ////////////////////

    regCycle uRegCycle (
        .CLK80(CLK80), .RESETn(RESETn), .C1(C1), .C3(C3), .TSn(TSn),
        .REGSPACEn(REGSPACEn), .DBRn(DBRn), .ASn(ASn), .REGENn(REGENn),
        .regTack(regTack), .dsEnable(dsEnable), .dbrSync(dbrSync)
    );

    chipRamCycle uChipRamCycle (
        .CLK80(CLK80), .RESETn(RESETn), .req(req), .RAMSPACEn(RAMSPACEn),
        .dma(dma), .dbrSync(dbrSync), .cmd(cmd), .cpuCycle(cpuCycle),
        .dmaCycle(dmaCycle), .cpuTack(cpuTack), .DBENn(DBENn), .DBDIR(DBDIR)
    );

    byteLaneControl uByteLaneControl (
        .req(req), .cpuCycle(cpuCycle), .dmaCycle(dmaCycle), .dsEnable(dsEnable),
        .CASLn(CASLn), .CASUn(CASUn), .RnW(RnW), .AWEn(AWEn), .ramBe(ramBe),
        .UDSn(UDSn), .LDSn(LDSn), .VBENn(VBENn), .DRDENn(DRDENn), .DRDDIR(DRDDIR)
    );

    // Single TACKn for both cycle types
    cycleTerm uCycleTerm (
        .CLK80(CLK80), .RESETn(RESETn), .regTack(regTack), .cpuTack(cpuTack),
        .TACKn(TACKn)
    );

endmodule

`default_nettype wire

// File: test/u712Tb.sv
// One transfer at a time, pins sampled at falling CLK80 and DMA strobes idle outside DMA
`timescale 1ns/1ps
`default_nettype none

module u712Tb import u712Pkg::*; ();

    localparam int          NUM_REG  = 6;
    localparam int          NUM_RAM  = 16;
    localparam int          NUM_XFER = NUM_REG + NUM_RAM + 1;
    localparam int          HALF_NS  = 50;
    localparam int unsigned SEED     = 32'h616f_aae4;
    // 40 cycles per transfer plus the reset cycles
    localparam longint      LIMIT_NS = (NUM_XFER * 40 + 4) * 2 * HALF_NS;

    logic   CLK80, C1, C3, RESETn, RnW, TSn, DBRn, REGSPACEn, RAMSPACEn;
    logic   AWEn, RAS0n, RAS1n, CASLn, CASUn;
    busSize SIZ;
    cpuAddr A;
    dmaAddr DRA;
    logic   LDSn, UDSn, ASn, REGENn, DBDIR, VBENn, DRDENn, DRDDIR, CRCSn, CLK_EN;
    logic   BANK1, BANK0, RASn, CASn, WEn, DBENn, TACKn;
    logic   CUUBEn, CUMBEn, CLMBEn, CLLBEn;
    ramAddr CMA;
    byteEn  lanes;
    logic [1:0] phaseCnt;
    int     tackCount = 0;
    int     tacksExpected = 0;
    int     xferNum = 0;
    string  testName = "reset";

    u712Top uut (.*);

    assign lanes = {CUUBEn, CUMBEn, CLMBEn, CLLBEn};

    ////////////////////
    // Clocks
    ////////////////////

    // C1 and C3 are CLK80 divided by 4 and a quarter apart
    initial begin
        CLK80 = 1'b0;
        C1 = 1'b0;
        C3 = 1'b0;
        phaseCnt = 2'd0;
        forever begin
            #HALF_NS CLK80 = 1'b1;
            #HALF_NS CLK80 = 1'b0;
            phaseCnt = phaseCnt + 2'd1;
            C1 = phaseCnt[1];
            C3 = phaseCnt[1] ^ phaseCnt[0];
        end
    end

    // Count TACKn low cycles on the rising edge
    always @(posedge CLK80) begin
        if (RESETn && TACKn === 1'b0) begin
            tackCount <= tackCount + 1;
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("Timeout: transfer %0d (%s) never finished", xferNum, testName);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Reference model
    ////////////////////

    // 68040 big-endian lanes active low with UU first
    function automatic byteEn expBe(input busSize sz, input logic [1:0] lowA);
        byteEn be;
        case (sz)
            2'b01: begin
                case (lowA)
                    2'd0: be = 4'b0111;
                    2'd1: be = 4'b1011;
                    2'd2: be = 4'b1101;
                    default: be = 4'b1110;
                endcase
            end
            2'b10: be = lowA[1] ? 4'b1100 : 4'b0011;
            default: be = 4'b0000;
        endcase
        return be;
    endfunction

    function automatic ramAddr expRow(input cpuAddr addr);
        return addr[18:8];
    endfunction

    function automatic ramAddr expCol(input cpuAddr addr);
        return {5'd0, addr[7:2]};
    endfunction

    function automatic logic [1:0] expBank(input cpuAddr addr);
        return addr[20:19];
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED %s: %s expected %b actual %b", testName, name, expVal, actVal);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkRamAddr(input string name, input ramAddr expVal, input ramAddr actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED %s: %s expected %h actual %h", testName, name, expVal, actVal);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkBe(input string name, input byteEn expVal, input byteEn actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED %s: %s expected %b actual %b", testName, name, expVal, actVal);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic checkCount(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d", testName, name, expVal, actVal);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    ////////////////////
    // Transfers
    ////////////////////

    // Register cycle paced by the phase clocks
    task automatic regTransfer();
        logic [31:0] rnd;
        byteEn       be;
        rnd = $urandom;
        testName = "register cycle";
        xferNum++;
        tacksExpected++;
        A = rnd[20:0];
        SIZ = rnd[22:21];
        RnW = rnd[23];
        be = expBe(rnd[22:21], rnd[1:0]);
        REGSPACEn = 1'b0;
        TSn = 1'b0;
        @(negedge CLK80);
        TSn = 1'b1;
        while (ASn !== 1'b0) begin
            checkBit("TACKn early", 1'b1, TACKn);
            @(negedge CLK80);
        end
        checkBit("REGENn with AS", 1'b0, REGENn);
        @(negedge CLK80);
        // Data strobes one clock behind AS
        checkBit("UDSn", be[3] & be[1], UDSn);
        checkBit("LDSn", be[2] & be[0], LDSn);
        checkBit("VBENn", 1'b0, VBENn);
        while (TACKn !== 1'b0) begin
            @(negedge CLK80);
        end
        checkBit("ASn released", 1'b1, ASn);
        checkBit("REGENn released", 1'b1, REGENn);
        REGSPACEn = 1'b1;
        @(negedge CLK80);
        checkBit("TACKn one cycle", 1'b1, TACKn);
        checkCount("TACKn pulses", tacksExpected, tackCount);
    endtask

    // One TSn cycle toward chip RAM
    task automatic ramRequest(input logic wr, input cpuAddr addr, input busSize sz);
        testName = wr ? "ram write" : "ram read";
        xferNum++;
        tacksExpected++;
        A = addr;
        SIZ = sz;
        RnW = ~wr;
        RAMSPACEn = 1'b0;
        TSn = 1'b0;
        @(negedge CLK80);
        TSn = 1'b1;
    endtask

    // Activate, command and TACKn at their fixed distances
    task automatic ramFinish(input logic wr, input cpuAddr addr, input busSize sz);
        logic [1:0] bank;
        int         tackGap;
        bank = expBank(addr);
        tackGap = wr ? 2 : 4;
        while (RASn !== 1'b0) begin
            @(negedge CLK80);
        end
        checkBit("BANK1", bank[1], BANK1);
        checkBit("BANK0", bank[0], BANK0);
        checkRamAddr("row", expRow(addr), CMA);
        checkBit("CRCSn at activate", 1'b0, CRCSn);
        checkBit("CLK_EN", 1'b1, CLK_EN);
        checkBe("lanes", expBe(sz, addr[1:0]), lanes);
        checkBit("DBDIR", wr, DBDIR);
        @(negedge CLK80);
        // First tRCD cycle is a NOP
        checkBit("RASn after activate", 1'b1, RASn);
        checkBit("CRCSn after activate", 1'b1, CRCSn);
        repeat (2) @(negedge CLK80);
        checkBit("CASn", 1'b0, CASn);
        checkBit("RASn at command", 1'b1, RASn);
        checkBit("WEn", ~wr, WEn);
        checkBit("CRCSn at command", 1'b0, CRCSn);
        checkRamAddr("column", expCol(addr), CMA);
        checkBit("DBENn", 1'b0, DBENn);
        repeat (tackGap) @(negedge CLK80);
        checkBit("TACKn", 1'b0, TACKn);
        checkBit("CASn after command", 1'b1, CASn);
        checkBit("WEn after command", 1'b1, WEn);
        checkBit("CRCSn after command", 1'b1, CRCSn);
        RAMSPACEn = 1'b1;
        @(negedge CLK80);
        checkBit("TACKn one cycle", 1'b1, TACKn);
        checkCount("TACKn pulses", tacksExpected, tackCount);
    endtask

    // Agnus pass-through followed by a CPU request held off by DMA
    task automatic dmaTest();
        logic [31:0] rnd;
        int          i;
        testName = "dma pass-through";
        DBRn = 1'b0;
        repeat (3) @(negedge CLK80);
        for (i = 0; i < 8; i++) begin
            rnd = $urandom;
            {RAS0n, RAS1n, CASLn, CASUn, AWEn} = rnd[14:10];
            DRA = rnd[9:0];
            @(negedge CLK80);
            checkBit("RASn", RAS0n & RAS1n, RASn);
            checkBit("CASn", CASLn & CASUn, CASn);
            checkBit("WEn", AWEn, WEn);
            checkBit("BANK1", ~RAS1n, BANK1);
            checkRamAddr("CMA", {1'b0, DRA}, CMA);
            checkBe("lanes", {CASUn, CASUn, CASLn, CASLn}, lanes);
            checkBit("DRDENn", 1'b0, DRDENn);
            checkBit("DRDDIR", AWEn, DRDDIR);
        end
        {RAS0n, RAS1n, CASLn, CASUn, AWEn} = 5'b11111;
        rnd = $urandom;
        ramRequest(1'b1, rnd[20:0], rnd[22:21]);
        testName = "ram during dma";
        // Request must wait for DBRn
        repeat (6) begin
            checkBit("RASn held off", 1'b1, RASn);
            checkRamAddr("CMA held off", {1'b0, DRA}, CMA);
            checkBit("TACKn held off", 1'b1, TACKn);
            @(negedge CLK80);
        end
        DBRn = 1'b1;
        ramFinish(1'b1, rnd[20:0], rnd[22:21]);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [31:0] rnd;
        int          i;
        RESETn = 1'b0;
        RnW = 1'b1;
        TSn = 1'b1;
        DBRn = 1'b1;
        REGSPACEn = 1'b1;
        RAMSPACEn = 1'b1;
        {RAS0n, RAS1n, CASLn, CASUn, AWEn} = 5'b11111;
        SIZ = 2'b00;
        A = '0;
        DRA = '0;
        void'($urandom(SEED));
        repeat (4) @(posedge CLK80);
        @(negedge CLK80);
        RESETn = 1'b1;
        repeat (2) @(negedge CLK80);
        checkBit("ASn", 1'b1, ASn);
        checkBit("REGENn", 1'b1, REGENn);
        checkBit("TACKn", 1'b1, TACKn);
        for (i = 0; i < NUM_REG; i++) begin
            regTransfer();
            @(negedge CLK80);
        end
        // A write and a read first and random directions after
        for (i = 0; i < NUM_RAM; i++) begin
            rnd = $urandom;
            if (i < 2) begin
                rnd[31] = (i == 0);
            end
            ramRequest(rnd[31], rnd[20:0], rnd[22:21]);
            ramFinish(rnd[31], rnd[20:0], rnd[22:21]);
            @(negedge CLK80);
        end
        dmaTest();
        repeat (4) @(negedge CLK80);
        testName = "end of run";
        checkCount("total TACKn pulses", tacksExpected, tackCount);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/u712Pkg.sv
src/regCycle.sv
src/chipRamCycle.sv
src/byteLaneControl.sv
src/cycleTerm.sv
src/u712Top.sv
test/u712Tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module u712Tb -f flist.f -o u712Sim \
    && ./obj_dir/u712Sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
